// File: project.f
+incdir+common
common/mips_pkg.sv
common/hazard_if.sv
src/fetch.sv
decode/reg_file.sv
decode/decode.sv
src/execute.sv
src/hazard_unit.sv
src/mips.sv
test/mips_props.sv
test/mips_tb.sv

// File: Makefile
TOP := mips_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/mips_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_settings.svh"

module mips_tb;

  localparam int ROM_WORDS = 128;
  localparam int RAM_WORDS = 256;
  localparam int N_RANDOM  = 24;

  logic                  clk_i;
  logic                  rst_n_i;
  logic [`MIPS_XLEN-1:0] instr_i;
  logic [`MIPS_XLEN-1:0] readdata_i;
  logic [`MIPS_XLEN-1:0] pc_o;
  logic                  memwrite_o;
  logic [`MIPS_XLEN-1:0] aluout_o;
  logic [`MIPS_XLEN-1:0] writedata_o;

  logic [`MIPS_XLEN-1:0] rom [ROM_WORDS];
  logic [`MIPS_XLEN-1:0] ram [RAM_WORDS];
  logic [`MIPS_XLEN-1:0] exp_addr [$];
  logic [`MIPS_XLEN-1:0] exp_data [$];
  logic [`MIPS_XLEN-1:0] halt_pc;
  logic [31:0]           seed;
  int                    prog_len;
  int                    n_stores;
  int                    addr_errors;
  int                    data_errors;
  int                    count_errors;
  int                    pc_errors;
  int                    other_errors;

  mips u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_i     (instr_i),
    .readdata_i  (readdata_i),
    .pc_o        (pc_o),
    .memwrite_o  (memwrite_o),
    .aluout_o    (aluout_o),
    .writedata_o (writedata_o)
  );

  always #10 clk_i = ~clk_i;

  // **********************************************************************
  // Encoders, random source and memory fill
  // **********************************************************************
  function automatic logic [31:0] enc_r(input mips_pkg::funct_e fn, input mips_pkg::reg_idx_t rd,
                                        input mips_pkg::reg_idx_t rs, input mips_pkg::reg_idx_t rt);
    mips_pkg::instr_u w;
    w.r.opcode = mips_pkg::OP_RTYPE;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = 5'd0;
    w.r.funct  = fn;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input mips_pkg::opcode_e op, input mips_pkg::reg_idx_t rt,
                                        input mips_pkg::reg_idx_t rs, input logic [15:0] imm);
    mips_pkg::instr_u w;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [25:0] target);
    mips_pkg::instr_u w;
    w.i.opcode                  = mips_pkg::OP_J;
    {w.i.rs, w.i.rt, w.i.imm}   = target;   // Word index
    return w;
  endfunction

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] idx);
    return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program();
    int                 k;
    mips_pkg::reg_idx_t rs;
    mips_pkg::reg_idx_t rt;
    mips_pkg::reg_idx_t rd;
    // Dependent chain, forwarding from M and W
    emit(enc_i(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5));
    emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd1, 16'hfff9));
    emit(enc_r(mips_pkg::FN_ADDU, 5'd3, 5'd1, 5'd2));
    emit(enc_r(mips_pkg::FN_SUBU, 5'd4, 5'd3, 5'd1));
    emit(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'd0));
    emit(enc_i(mips_pkg::OP_SW, 5'd3, 5'd0, 16'd4));
    // Register 0 stays zero even when written
    emit(enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0077));
    emit(enc_i(mips_pkg::OP_SW, 5'd0, 5'd0, 16'd60));
    // Load followed by a use
    emit(enc_i(mips_pkg::OP_LW, 5'd5, 5'd0, 16'd8));
    emit(enc_r(mips_pkg::FN_ADDU, 5'd6, 5'd5, 5'd1));
    emit(enc_i(mips_pkg::OP_SW, 5'd6, 5'd0, 16'd12));
    emit(enc_i(mips_pkg::OP_LW, 5'd7, 5'd0, 16'd16));
    emit(enc_i(mips_pkg::OP_SW, 5'd7, 5'd0, 16'd20));
    // Branches and jump
    emit(enc_i(mips_pkg::OP_ADDIU, 5'd8, 5'd0, 16'd3));
    emit(enc_i(mips_pkg::OP_BEQ, 5'd3, 5'd8, 16'd1));     // Taken, r8 from the ALU op
    emit(enc_i(mips_pkg::OP_SW, 5'd8, 5'd0, 16'd24));     // Skipped
    emit(enc_i(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd28));
    emit(enc_i(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd1));     // Not taken
    emit(enc_i(mips_pkg::OP_SW, 5'd2, 5'd0, 16'd32));
    emit(enc_j(26'(prog_len + 2)));
    emit(enc_i(mips_pkg::OP_SW, 5'd3, 5'd0, 16'd36));     // Skipped
    emit(enc_i(mips_pkg::OP_LW, 5'd9, 5'd0, 16'd4));
    emit(enc_i(mips_pkg::OP_BEQ, 5'd3, 5'd9, 16'd1));     // Load right before, taken
    emit(enc_i(mips_pkg::OP_SW, 5'd0, 5'd0, 16'd48));     // Skipped
    emit(enc_i(mips_pkg::OP_SW, 5'd9, 5'd0, 16'd52));
    emit(enc_i(mips_pkg::OP_LW, 5'd10, 5'd0, 16'd0));
    emit(enc_i(mips_pkg::OP_ADDIU, 5'd11, 5'd0, 16'hfffe));
    emit(enc_i(mips_pkg::OP_BEQ, 5'd11, 5'd10, 16'd1));   // Load two back, taken
    emit(enc_i(mips_pkg::OP_SW, 5'd11, 5'd0, 16'd48));    // Skipped
    emit(enc_i(mips_pkg::OP_SW, 5'd10, 5'd0, 16'd56));
    // Random operands, half from immediates and half full-width from RAM
    for (k = 0; k < 4; k++) begin
      seed = lcg(seed);
      emit(enc_i(mips_pkg::OP_ADDIU, 5'(12 + k), 5'd0, seed[31:16]));
      emit(enc_i(mips_pkg::OP_LW, 5'(16 + k), 5'd0, 16'(4 * (100 + k))));
    end
    for (k = 0; k < N_RANDOM; k++) begin
      seed = lcg(seed);
      rs   = 5'(12 + seed[27:24]);
      rt   = 5'(12 + seed[23:20]);
      rd   = 5'(20 + seed[18:16]);
      case (k % 6)
        0:       emit(enc_r(mips_pkg::FN_ADDU, rd, rs, rt));
        1:       emit(enc_r(mips_pkg::FN_SUBU, rd, rs, rt));
        2:       emit(enc_r(mips_pkg::FN_AND, rd, rs, rt));
        3:       emit(enc_r(mips_pkg::FN_OR, rd, rs, rt));
        4:       emit(enc_r(mips_pkg::FN_SLT, rd, rs, rt));
        default: emit(enc_i(mips_pkg::OP_ADDIU, rd, rs, seed[15:0]));
      endcase
      emit(enc_i(mips_pkg::OP_SW, rd, 5'd0, 16'(64 + 4 * k)));
    end
    halt_pc = prog_len * 4;
    emit(enc_j(26'(prog_len)));   // Spin here
  endtask

  // **********************************************************************
  // Instruction-level reference model
  // **********************************************************************
  function automatic void run_model();
    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
    logic [`MIPS_XLEN-1:0] dmem [RAM_WORDS];
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] npc;
    logic [`MIPS_XLEN-1:0] a;
    logic [`MIPS_XLEN-1:0] b;
    logic [`MIPS_XLEN-1:0] sext;
    logic [`MIPS_XLEN-1:0] addr;
    mips_pkg::instr_u      ins;
    logic                  halted;
    int                    i;
    for (i = 0; i < `MIPS_NREGS; i++) regs[i] = '0;
    for (i = 0; i < RAM_WORDS; i++) dmem[i] = fill_word(i);
    pc     = `MIPS_RESET_PC;
    halted = 1'b0;
    for (i = 0; i < 4 * ROM_WORDS && !halted; i++) begin
      ins  = rom[pc[8:2]];
      a    = regs[ins.r.rs];
      b    = regs[ins.r.rt];
      sext = {{16{ins.i.imm[15]}}, ins.i.imm};
      addr = a + sext;
      npc  = pc + 4;
      case (ins.r.opcode)
        mips_pkg::OP_RTYPE: begin
          case (ins.r.funct)
            mips_pkg::FN_ADDU: regs[ins.r.rd] = a + b;
            mips_pkg::FN_SUBU: regs[ins.r.rd] = a - b;
            mips_pkg::FN_AND:  regs[ins.r.rd] = a & b;
            mips_pkg::FN_OR:   regs[ins.r.rd] = a | b;
            mips_pkg::FN_SLT:  regs[ins.r.rd] = ($signed(a) < $signed(b)) ? 1 : 0;
            default: ;
          endcase
        end
        mips_pkg::OP_ADDIU: regs[ins.i.rt] = addr;
        mips_pkg::OP_LW:    regs[ins.i.rt] = dmem[addr[9:2]];
        mips_pkg::OP_SW: begin
          dmem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        mips_pkg::OP_BEQ: if (a == b) npc = npc + {sext[29:0], 2'b00};
        mips_pkg::OP_J:   npc = {npc[31:28], ins.i.rs, ins.i.rt, ins.i.imm, 2'b00};
        default: ;
      endcase
      regs[0] = '0;
      halted  = (npc == pc);
      pc      = npc;
    end
  endfunction

  // **********************************************************************
  // Checks and verdict
  // **********************************************************************
  task automatic check_addr(input logic [`MIPS_XLEN-1:0] got, input logic [`MIPS_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR aluout_o store %0d got %h expected %h", n_stores, got, exp);
      addr_errors++;
    end
  endtask

  task automatic check_data(input logic [`MIPS_XLEN-1:0] got, input logic [`MIPS_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR writedata_o store %0d got %h expected %h", n_stores, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_pc(input logic [`MIPS_XLEN-1:0] got, input logic [`MIPS_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR pc_o got %h expected %h", got, exp);
      pc_errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      $display("ERROR memwrite_o pulse count got %h expected %h", got, exp);
      count_errors++;
    end
  endtask

  task automatic finish_run();
    $display("stores %0d of %0d, address errors %0d, data errors %0d,",
             n_stores, exp_addr.size(), addr_errors, data_errors,
             " count errors %0d, pc errors %0d, other %0d",
             count_errors, pc_errors, other_errors);
    if (addr_errors + data_errors + count_errors + pc_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // Memories are read asynchronously, driven on the falling edge
  always @(negedge clk_i) begin
    if (memwrite_o === 1'b1) ram[aluout_o[9:2]] = writedata_o;
    instr_i    = rom[pc_o[8:2]];
    readdata_i = ram[aluout_o[9:2]];
  end

  always @(negedge clk_i) begin
    if (memwrite_o === 1'b1) begin
      if (n_stores < exp_addr.size()) begin
        check_addr(aluout_o, exp_addr[n_stores]);
        check_data(writedata_o, exp_data[n_stores]);
      end else begin
        $display("unexpected extra store to address %h", aluout_o);
        other_errors++;
      end
      n_stores++;
    end
  end

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    instr_i      = '0;
    readdata_i   = '0;
    seed         = 32'h2f46;
    prog_len     = 0;
    n_stores     = 0;
    addr_errors  = 0;
    data_errors  = 0;
    count_errors = 0;
    pc_errors    = 0;
    other_errors = 0;
    for (int i = 0; i < ROM_WORDS; i++) rom[i] = '0;
    for (int i = 0; i < RAM_WORDS; i++) ram[i] = fill_word(i);
    build_program();
    run_model();
    repeat (16) @(negedge clk_i);
    check_pc(pc_o, `MIPS_RESET_PC);   // PC held at its reset value
    rst_n_i = 1'b1;
    @(negedge clk_i);
    while (pc_o != halt_pc) @(negedge clk_i);
    repeat (5) @(posedge clk_i);   // Drain what is still in flight
    check_count(n_stores, exp_addr.size());
    finish_run();
  end

  // Watchdog
  initial begin
    wait (rst_n_i === 1'b1);
    repeat (prog_len * 8) @(posedge clk_i);
    $display("timeout, the program did not reach its end within %0d cycles", prog_len * 8);
    other_errors++;
    finish_run();
  end

endmodule

`default_nettype wire

// File: test/mips_props.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_settings.svh"

module mips_props (
  input wire                     clk_i,
  input wire                     rst_n_i,
  input wire                     memwrite_i,
  input wire                     stall_d_i,
  input wire [`MIPS_XLEN-1:0]    pc_i,
  input wire [`MIPS_XLEN-1:0]    instr_d_i,
  input wire mips_pkg::ctrl_t    ctrl_e_i,
  input wire mips_pkg::reg_idx_t rs_d_i,
  input wire [`MIPS_XLEN-1:0]    cmp_a_i
);

  a_reset_no_store: assert property (@(posedge clk_i) !rst_n_i |=> !memwrite_i)
    else $error("store strobe high after a reset cycle");

  // Fetch and decode freeze together
  a_stall_pair: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                 stall_d_i |=> $stable(pc_i) && $stable(instr_d_i))
    else $error("PC or F/D register moved during a decode stall");

  a_stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                   stall_d_i |=> ctrl_e_i == '0)
    else $error("decode stalled without a bubble into execute");

  // Register 0 reads as zero even with a write to it in flight
  a_zero_reg: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                               rs_d_i == '0 |-> cmp_a_i == '0)
    else $error("register 0 read as nonzero in decode");

endmodule

bind mips mips_props u_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .memwrite_i (memwrite_o),
  .stall_d_i  (u_hz.stall_d),
  .pc_i       (pc_o),
  .instr_d_i  (instr_d),
  .ctrl_e_i   (ctrl_e),
  .rs_d_i     (u_hz.rs_d),
  .cmp_a_i    (u_decode.cmp_a)
);

`default_nettype wire

// File: src/mips.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_settings.svh"

// Five-stage pipelined core with external instruction and data memories
module mips (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire [`MIPS_XLEN-1:0]   instr_i,
  input  wire [`MIPS_XLEN-1:0]   readdata_i,
  output logic [`MIPS_XLEN-1:0]  pc_o,
  output logic                   memwrite_o,
  output logic [`MIPS_XLEN-1:0]  aluout_o,
  output logic [`MIPS_XLEN-1:0]  writedata_o
);

  logic [`MIPS_XLEN-1:0] pc_plus4_d;
  logic [`MIPS_XLEN-1:0] instr_d;
  logic [`MIPS_XLEN-1:0] pc_branch_d;
  logic                  pc_src_d;
  logic                  jump_d;
  logic [`MIPS_XLEN-1:0] jump_target_d;
  logic                  flush_d;

  mips_pkg::ctrl_t       ctrl_e;
  logic [`MIPS_XLEN-1:0] rd1_e;
  logic [`MIPS_XLEN-1:0] rd2_e;
  mips_pkg::reg_idx_t    rd_e;
  logic [`MIPS_XLEN-1:0] imm_e;

  logic [`MIPS_XLEN-1:0] alu_out_m;
  logic                  reg_write_w;
  mips_pkg::reg_idx_t    write_reg_w;
  logic [`MIPS_XLEN-1:0] result_w;

  hazard_if u_hz ();

  assign flush_d  = pc_src_d | jump_d;   // One wrongly fetched slot
  assign aluout_o = alu_out_m;

  fetch u_fetch (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .hz              (u_hz),
    .instr_f_i       (instr_i),
    .pc_branch_d_i   (pc_branch_d),
    .pc_src_d_i      (pc_src_d),
    .jump_d_i        (jump_d),
    .jump_target_d_i (jump_target_d),
    .flush_d_i       (flush_d),
    .pc_f_o          (pc_o),
    .pc_plus4_d_o    (pc_plus4_d),
    .instr_d_o       (instr_d)
  );

  decode u_decode (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .pc_plus4_d_i    (pc_plus4_d),
    .instr_d_i       (instr_d),
    .alu_out_m_i     (alu_out_m),
    .reg_write_w_i   (reg_write_w),
    .write_reg_w_i   (write_reg_w),
    .result_w_i      (result_w),
    .hz              (u_hz),
    .pc_src_d_o      (pc_src_d),
    .pc_branch_d_o   (pc_branch_d),
    .jump_d_o        (jump_d),
    .jump_target_d_o (jump_target_d),
    .ctrl_e_o        (ctrl_e),
    .rd1_e_o         (rd1_e),
    .rd2_e_o         (rd2_e),
    .rd_e_o          (rd_e),
    .imm_e_o         (imm_e)
  );

  execute u_execute (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ctrl_e_i       (ctrl_e),
    .rd1_e_i        (rd1_e),
    .rd2_e_i        (rd2_e),
    .rd_e_i         (rd_e),
    .imm_e_i        (imm_e),
    .readdata_m_i   (readdata_i),
    .hz             (u_hz),
    .alu_out_m_o    (alu_out_m),
    .write_data_m_o (writedata_o),
    .mem_write_m_o  (memwrite_o),
    .reg_write_w_o  (reg_write_w),
    .write_reg_w_o  (write_reg_w),
    .result_w_o     (result_w)
  );

  hazard_unit u_hazard_unit (
    .hz (u_hz)
  );

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  hazard_if.hazard hz
);

  logic lw_stall;
  logic branch_stall;

  function automatic logic [1:0] fwd_e_sel(input mips_pkg::reg_idx_t src);
    if (src != '0 && hz.reg_write_m && src == hz.write_reg_m) return 2'd2;
    if (src != '0 && hz.reg_write_w && src == hz.write_reg_w) return 2'd1;
    return 2'd0;
  endfunction

  // True when dst is read by the instruction in decode
  function automatic logic read_in_d(input mips_pkg::reg_idx_t dst);
    return dst != '0 && (dst == hz.rs_d || dst == hz.rt_d);
  endfunction

  assign hz.fwd_a_e = fwd_e_sel(hz.rs_e);   // Newest producer wins
  assign hz.fwd_b_e = fwd_e_sel(hz.rt_e);

  assign hz.fwd_a_d = hz.rs_d != '0 && hz.reg_write_m && hz.rs_d == hz.write_reg_m;
  assign hz.fwd_b_d = hz.rt_d != '0 && hz.reg_write_m && hz.rt_d == hz.write_reg_m;

  assign lw_stall = hz.mem_to_reg_e && read_in_d(hz.write_reg_e);

  // Branch compares in decode, so results still in E or loads in M are too late
  assign branch_stall = hz.branch_d &&
                        ((hz.reg_write_e && read_in_d(hz.write_reg_e)) ||
                         (hz.mem_to_reg_m && read_in_d(hz.write_reg_m)));

  assign hz.stall_f = lw_stall || branch_stall;
  assign hz.stall_d = lw_stall || branch_stall;
  assign hz.flush_e = lw_stall || branch_stall;  // Bubble into execute

endmodule

`default_nettype wire

// File: src/execute.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_settings.svh"

module execute (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  input  wire mips_pkg::ctrl_t     ctrl_e_i,
  input  wire [`MIPS_XLEN-1:0]     rd1_e_i,
  input  wire [`MIPS_XLEN-1:0]     rd2_e_i,
  input  wire mips_pkg::reg_idx_t  rd_e_i,
  input  wire [`MIPS_XLEN-1:0]     imm_e_i,
  input  wire [`MIPS_XLEN-1:0]     readdata_m_i,
  hazard_if.execute                hz,
  output logic [`MIPS_XLEN-1:0]    alu_out_m_o,
  output logic [`MIPS_XLEN-1:0]    write_data_m_o,
  output logic                     mem_write_m_o,
  output logic                     reg_write_w_o,
  output mips_pkg::reg_idx_t       write_reg_w_o,
  output logic [`MIPS_XLEN-1:0]    result_w_o
);

  logic [`MIPS_XLEN-1:0] src_a;
  logic [`MIPS_XLEN-1:0] src_b;
  logic [`MIPS_XLEN-1:0] write_data_e;
  logic [`MIPS_XLEN-1:0] alu_out_e;
  mips_pkg::reg_idx_t    write_reg_e;
  mips_pkg::reg_idx_t    write_reg_m;
  logic                  reg_write_m;
  logic                  mem_to_reg_m;

  function automatic logic [`MIPS_XLEN-1:0] fwd_mux(input logic [1:0] sel,
                                                    input logic [`MIPS_XLEN-1:0] reg_val);
    case (sel)
      2'd1:    return result_w_o;
      2'd2:    return alu_out_m_o;
      default: return reg_val;
    endcase
  endfunction

  assign src_a        = fwd_mux(hz.fwd_a_e, rd1_e_i);
  assign write_data_e = fwd_mux(hz.fwd_b_e, rd2_e_i);   // Store data also forwarded
  assign src_b        = ctrl_e_i.alu_src_imm ? imm_e_i : write_data_e;
  assign write_reg_e  = ctrl_e_i.reg_dst_rd ? rd_e_i : hz.rt_e;

  always_comb begin
    case (ctrl_e_i.alu_op)
      mips_pkg::ALU_ADD: alu_out_e = src_a + src_b;
      mips_pkg::ALU_SUB: alu_out_e = src_a - src_b;
      mips_pkg::ALU_AND: alu_out_e = src_a & src_b;
      mips_pkg::ALU_OR:  alu_out_e = src_a | src_b;
      mips_pkg::ALU_SLT: alu_out_e = {{(`MIPS_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      default:           alu_out_e = '0;
    endcase
  end

  // **********************************************************************
  // E/M and M/W pipeline registers
  // **********************************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      reg_write_m   <= 1'b0;
      mem_to_reg_m  <= 1'b0;
      mem_write_m_o <= 1'b0;
      reg_write_w_o <= 1'b0;
    end else begin
      reg_write_m   <= ctrl_e_i.reg_write;
      mem_to_reg_m  <= ctrl_e_i.mem_to_reg;
      mem_write_m_o <= ctrl_e_i.mem_write;
      reg_write_w_o <= reg_write_m;
    end
  end

  always_ff @(posedge clk_i) begin
    alu_out_m_o    <= alu_out_e;
    write_data_m_o <= write_data_e;
    write_reg_m    <= write_reg_e;
    write_reg_w_o  <= write_reg_m;
    result_w_o     <= mem_to_reg_m ? readdata_m_i : alu_out_m_o;  // Load data or ALU value
  end

  assign hz.write_reg_e  = write_reg_e;
  assign hz.reg_write_e  = ctrl_e_i.reg_write;
  assign hz.mem_to_reg_e = ctrl_e_i.mem_to_reg;
  assign hz.write_reg_m  = write_reg_m;
  assign hz.reg_write_m  = reg_write_m;
  assign hz.mem_to_reg_m = mem_to_reg_m;
  assign hz.write_reg_w  = write_reg_w_o;
  assign hz.reg_write_w  = reg_write_w_o;

endmodule

`default_nettype wire

// File: decode/decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_settings.svh"

module decode (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  input  wire [`MIPS_XLEN-1:0]     pc_plus4_d_i,
  input  wire [`MIPS_XLEN-1:0]     instr_d_i,
  input  wire [`MIPS_XLEN-1:0]     alu_out_m_i,
  input  wire                      reg_write_w_i,
  input  wire mips_pkg::reg_idx_t  write_reg_w_i,
  input  wire [`MIPS_XLEN-1:0]     result_w_i,
  hazard_if.decode                 hz,
  output logic                     pc_src_d_o,
  output logic [`MIPS_XLEN-1:0]    pc_branch_d_o,
  output logic                     jump_d_o,
  output logic [`MIPS_XLEN-1:0]    jump_target_d_o,
  output mips_pkg::ctrl_t          ctrl_e_o,
  output logic [`MIPS_XLEN-1:0]    rd1_e_o,
  output logic [`MIPS_XLEN-1:0]    rd2_e_o,
  output mips_pkg::reg_idx_t       rd_e_o,
  output logic [`MIPS_XLEN-1:0]    imm_e_o
);

  mips_pkg::instr_u      instr;
  mips_pkg::ctrl_t       ctrl_d;
  logic                  branch_d;
  logic                  jump_d;
  logic [`MIPS_XLEN-1:0] rd1_d;
  logic [`MIPS_XLEN-1:0] rd2_d;
  logic [`MIPS_XLEN-1:0] cmp_a;
  logic [`MIPS_XLEN-1:0] cmp_b;
  logic [`MIPS_XLEN-1:0] imm_d;

  assign instr = instr_d_i;

  // **********************************************************************
  // Control decode
  // **********************************************************************
  always_comb begin
    ctrl_d   = '0;
    branch_d = 1'b0;
    jump_d   = 1'b0;
    case (instr.r.opcode)
      mips_pkg::OP_RTYPE: begin
        ctrl_d.reg_write  = 1'b1;
        ctrl_d.reg_dst_rd = 1'b1;
        case (instr.r.funct)
          mips_pkg::FN_ADDU: ctrl_d.alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: ctrl_d.alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  ctrl_d.alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   ctrl_d.alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_SLT:  ctrl_d.alu_op = mips_pkg::ALU_SLT;
          default:           ctrl_d = '0;  // Unknown function, no-op
        endcase
      end
      mips_pkg::OP_ADDIU: begin
        ctrl_d.reg_write   = 1'b1;
        ctrl_d.alu_src_imm = 1'b1;
      end
      mips_pkg::OP_LW: begin
        ctrl_d.reg_write   = 1'b1;
        ctrl_d.mem_to_reg  = 1'b1;
        ctrl_d.alu_src_imm = 1'b1;
      end
      mips_pkg::OP_SW: begin
        ctrl_d.mem_write   = 1'b1;
        ctrl_d.alu_src_imm = 1'b1;
      end
      mips_pkg::OP_BEQ: branch_d = 1'b1;
      mips_pkg::OP_J:   jump_d   = 1'b1;
      default: ;
    endcase
  end

  reg_file u_reg_file (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .ra1_i   (instr.r.rs),
    .ra2_i   (instr.r.rt),
    .rd1_o   (rd1_d),
    .rd2_o   (rd2_d),
    .we_i    (reg_write_w_i),
    .wa_i    (write_reg_w_i),
    .wd_i    (result_w_i)
  );

  assign imm_d = {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};

  // Branch compare, operands may come from the memory stage
  assign cmp_a = hz.fwd_a_d ? alu_out_m_i : rd1_d;
  assign cmp_b = hz.fwd_b_d ? alu_out_m_i : rd2_d;

  // Redirect only once the operands are final
  assign pc_src_d_o      = branch_d && (cmp_a == cmp_b) && !hz.stall_d;
  assign jump_d_o        = jump_d && !hz.stall_d;
  assign pc_branch_d_o   = pc_plus4_d_i + {imm_d[`MIPS_XLEN-3:0], 2'b00};
  assign jump_target_d_o = {pc_plus4_d_i[`MIPS_XLEN-1:28], instr.i.rs, instr.i.rt,
                            instr.i.imm, 2'b00};

  assign hz.rs_d     = instr.r.rs;
  assign hz.rt_d     = instr.r.rt;
  assign hz.branch_d = branch_d;

  // **********************************************************************
  // D/E pipeline register
  // **********************************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || hz.flush_e) begin
      ctrl_e_o <= '0;              // Bubble
      hz.rs_e  <= '0;
      hz.rt_e  <= '0;
      rd_e_o   <= '0;
    end else begin
      ctrl_e_o <= ctrl_d;
      hz.rs_e  <= instr.r.rs;
      hz.rt_e  <= instr.r.rt;
      rd_e_o   <= instr.r.rd;
    end
  end

  always_ff @(posedge clk_i) begin
    rd1_e_o <= rd1_d;
    rd2_e_o <= rd2_d;
    imm_e_o <= imm_d;
  end

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_settings.svh"

module reg_file (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire mips_pkg::reg_idx_t ra1_i,
  input  wire mips_pkg::reg_idx_t ra2_i,
  output logic [`MIPS_XLEN-1:0]  rd1_o,
  output logic [`MIPS_XLEN-1:0]  rd2_o,
  input  wire                    we_i,
  input  wire mips_pkg::reg_idx_t wa_i,
  input  wire [`MIPS_XLEN-1:0]   wd_i
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MIPS_NREGS; i++) regs[i] <= '0;
    end else if (we_i && wa_i != '0) begin
      regs[wa_i] <= wd_i;
    end
  end

  // Writeback result is visible to decode in the same cycle
  assign rd1_o = (ra1_i == '0)                ? '0   :
                 (we_i && wa_i == ra1_i)      ? wd_i : regs[ra1_i];
  assign rd2_o = (ra2_i == '0)                ? '0   :
                 (we_i && wa_i == ra2_i)      ? wd_i : regs[ra2_i];

endmodule

`default_nettype wire

// File: src/fetch.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_settings.svh"

module fetch (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  hazard_if.fetch                hz,
  input  wire [`MIPS_XLEN-1:0]   instr_f_i,
  input  wire [`MIPS_XLEN-1:0]   pc_branch_d_i,
  input  wire                    pc_src_d_i,
  input  wire                    jump_d_i,
  input  wire [`MIPS_XLEN-1:0]   jump_target_d_i,
  input  wire                    flush_d_i,
  output logic [`MIPS_XLEN-1:0]  pc_f_o,
  output logic [`MIPS_XLEN-1:0]  pc_plus4_d_o,
  output logic [`MIPS_XLEN-1:0]  instr_d_o
);

  logic [`MIPS_XLEN-1:0] pc_plus4_f;
  logic [`MIPS_XLEN-1:0] pc_next;

  assign pc_plus4_f = pc_f_o + 'd4;
  assign pc_next    = jump_d_i   ? jump_target_d_i :
                      pc_src_d_i ? pc_branch_d_i   : pc_plus4_f;

  // Stall freezes PC and F/D together
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_f_o    <= `MIPS_RESET_PC;
      instr_d_o <= '0;
    end else if (!hz.stall_f) begin
      pc_f_o    <= pc_next;
      instr_d_o <= flush_d_i ? '0 : instr_f_i;  // Wrong-path slot becomes a no-op
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hz.stall_f) pc_plus4_d_o <= pc_plus4_f;
  end

endmodule

`default_nettype wire

// File: common/hazard_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hazard_if;

  mips_pkg::reg_idx_t rs_d;
  mips_pkg::reg_idx_t rt_d;
  logic               branch_d;
  mips_pkg::reg_idx_t rs_e;
  mips_pkg::reg_idx_t rt_e;
  mips_pkg::reg_idx_t write_reg_e;
  logic               reg_write_e;
  logic               mem_to_reg_e;
  mips_pkg::reg_idx_t write_reg_m;
  logic               reg_write_m;
  logic               mem_to_reg_m;
  mips_pkg::reg_idx_t write_reg_w;
  logic               reg_write_w;

  logic               stall_f;
  logic               stall_d;
  logic               flush_e;
  logic               fwd_a_d;       // ALU result from memory stage
  logic               fwd_b_d;
  logic [1:0]         fwd_a_e;       // 0 register, 1 writeback, 2 memory
  logic [1:0]         fwd_b_e;

  modport fetch (input stall_f);

  modport decode (
    output rs_d, rt_d, branch_d, rs_e, rt_e,
    input  stall_d, flush_e, fwd_a_d, fwd_b_d
  );

  modport execute (
    input  rt_e, fwd_a_e, fwd_b_e,
    output write_reg_e, reg_write_e, mem_to_reg_e,
    output write_reg_m, reg_write_m, mem_to_reg_m,
    output write_reg_w, reg_write_w
  );

  modport hazard (
    input  rs_d, rt_d, branch_d, rs_e, rt_e,
    input  write_reg_e, reg_write_e, mem_to_reg_e,
    input  write_reg_m, reg_write_m, mem_to_reg_m,
    input  write_reg_w, reg_write_w,
    output stall_f, stall_d, flush_e, fwd_a_d, fwd_b_d, fwd_a_e, fwd_b_e
  );

endinterface

`default_nettype wire

// File: common/mips_pkg.sv
`default_nettype none

package mips_pkg;

  typedef logic [4:0] reg_idx_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_ADDIU = 6'h09,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_type_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } i_type_t;

  // Same word seen as register or immediate format
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;
    logic    mem_write;
    logic    alu_src_imm;
    logic    reg_dst_rd;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

`default_nettype wire

// File: common/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data and address width
`define MIPS_XLEN 32

// Architectural register count
`define MIPS_NREGS 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif
